// File: source/tcdm_pkg.sv
// Package with TCDM cluster sizes, address field types and payload structs
package tcdm_pkg;

  // Cluster sizes
  localparam int unsigned NumCores      = 4;
  localparam int unsigned BankingFactor = 2;
  localparam int unsigned NumBanks      = NumCores * BankingFactor;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned BeWidth       = DataWidth / 8;
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned BankWords     = 64;
  localparam int unsigned FifoDepth     = 4;

  // Address fields, word interleaved across the banks
  localparam int unsigned ByteOffset   = $clog2(BeWidth);
  localparam int unsigned BankSel      = $clog2(NumBanks);
  localparam int unsigned RowWidth     = $clog2(BankWords);
  localparam int unsigned CoreIdxWidth = $clog2(NumCores);

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [BeWidth-1:0]      be_t;
  typedef logic [BankSel-1:0]      bank_idx_t;
  typedef logic [RowWidth-1:0]     row_t;
  typedef logic [CoreIdxWidth-1:0] core_idx_t;

  // Core side
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    be_t   be;
  } tcdm_req_t;

  typedef struct packed {
    data_t rdata;
  } tcdm_resp_t;

  // Bank side, tagged with the requesting core
  typedef struct packed {
    row_t      row;
    logic      we;
    data_t     wdata;
    be_t       be;
    core_idx_t core_idx;
  } bank_req_t;

  typedef struct packed {
    data_t     rdata;
    core_idx_t core_idx;
  } bank_resp_t;

endpackage

// File: source/stream_fifo.sv
// Generic valid/ready FIFO with a type parameter and a space-ahead ready rule
module stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  localparam int unsigned PtrWidth   = $clog2(Depth);
  localparam int unsigned CntWidth   = $clog2(Depth + 1);
  localparam int unsigned ReadyLimit = Depth - 2;

  payload_t              mem_q [Depth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [CntWidth-1:0]   count_q;
  logic                  push;
  logic                  pop;

  // Ready keeps one slot in reserve for an item already on its way
  assign ready_o = (count_q <= ReadyLimit);
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  // The reserve slot still takes an item while ready is low
  assign push = valid_i && (count_q != CntWidth'(Depth));
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: source/tcdm_xbar.sv
// Crossbar with per-bank round-robin arbiters, bank request and response routing
module tcdm_xbar import tcdm_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Request FIFO heads
  input  tcdm_req_t  [NumCores-1:0]  core_req_i,
  input  logic       [NumCores-1:0]  core_req_valid_i,
  output logic       [NumCores-1:0]  core_req_gnt_o,
  // Response FIFO space
  input  logic       [NumCores-1:0]  resp_space_i,
  // Banks
  output bank_req_t  [NumBanks-1:0]  bank_req_o,
  output logic       [NumBanks-1:0]  bank_req_valid_o,
  input  bank_resp_t [NumBanks-1:0]  bank_resp_i,
  input  logic       [NumBanks-1:0]  bank_resp_valid_i,
  // Responses towards the cores
  output tcdm_resp_t [NumCores-1:0]  core_resp_o,
  output logic       [NumCores-1:0]  core_resp_valid_o
);

  bank_idx_t [NumCores-1:0] core_bank;
  row_t      [NumCores-1:0] core_row;
  logic      [NumCores-1:0] core_eligible;
  core_idx_t [NumBanks-1:0] winner;
  core_idx_t [NumBanks-1:0] rr_ptr_q;

  // Bank and row decode
  always_comb begin
    for (int c = 0; c < NumCores; c++) begin
      core_bank[c] = core_req_i[c].addr[ByteOffset +: BankSel];
      core_row[c]  = core_req_i[c].addr[ByteOffset + BankSel +: RowWidth];
      // A read needs room for its response
      core_eligible[c] = core_req_valid_i[c] && (core_req_i[c].we || resp_space_i[c]);
    end
  end

  // Round-robin search starting at each bank's pointer
  always_comb begin
    core_idx_t idx;
    idx              = '0;
    winner           = '0;
    bank_req_valid_o = '0;
    core_req_gnt_o   = '0;
    for (int b = 0; b < NumBanks; b++) begin
      // Walk backwards so the first match after the pointer wins
      for (int k = NumCores - 1; k >= 0; k--) begin
        idx = rr_ptr_q[b] + core_idx_t'(k);
        if (core_eligible[idx] && (core_bank[idx] == bank_idx_t'(b))) begin
          winner[b]           = idx;
          bank_req_valid_o[b] = 1'b1;
        end
      end
      if (bank_req_valid_o[b]) begin
        core_req_gnt_o[winner[b]] = 1'b1;
      end
    end
  end

  // Winning request goes to its bank
  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      bank_req_o[b].row      = core_row[winner[b]];
      bank_req_o[b].we       = core_req_i[winner[b]].we;
      bank_req_o[b].wdata    = core_req_i[winner[b]].wdata;
      bank_req_o[b].be       = core_req_i[winner[b]].be;
      bank_req_o[b].core_idx = winner[b];
    end
  end

  // Pointer moves one past the winner, wrapping over the core count
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else begin
      for (int b = 0; b < NumBanks; b++) begin
        if (bank_req_valid_o[b]) begin
          rr_ptr_q[b] <= winner[b] + 1'b1;
        end
      end
    end
  end

  // Responses steered by core index
  // One grant per core per cycle, so no two banks name the same core
  always_comb begin
    core_resp_o       = '0;
    core_resp_valid_o = '0;
    for (int b = 0; b < NumBanks; b++) begin
      if (bank_resp_valid_i[b]) begin
        core_resp_valid_o[bank_resp_i[b].core_idx]   = 1'b1;
        core_resp_o[bank_resp_i[b].core_idx].rdata   = bank_resp_i[b].rdata;
      end
    end
  end

endmodule

// File: source/tcdm_bank.sv
// Single SRAM bank with byte-enable writes and registered, core-tagged read data
module tcdm_bank import tcdm_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  bank_req_t  req_i,
  input  logic       req_valid_i,
  output bank_resp_t resp_o,
  output logic       resp_valid_o
);

  data_t mem_q [BankWords];
  logic  rd_req;

  assign rd_req = req_valid_i && !req_i.we;

  // Byte lane writes
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_i.we) begin
      for (int i = 0; i < BeWidth; i++) begin
        if (req_i.be[i]) begin
          mem_q[req_i.row][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // Read data and return tag, one cycle after the request
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      resp_o.rdata    <= mem_q[req_i.row];
      resp_o.core_idx <= req_i.core_idx;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= rd_req;
    end
  end

endmodule

// File: source/tcdm_cluster.sv
// Cluster top with request FIFOs, crossbar, banks and response FIFOs
module tcdm_cluster import tcdm_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Core requests
  input  tcdm_req_t  [NumCores-1:0] core_req_i,
  input  logic       [NumCores-1:0] core_req_valid_i,
  output logic       [NumCores-1:0] core_req_ready_o,
  // Core responses
  output tcdm_resp_t [NumCores-1:0] core_resp_o,
  output logic       [NumCores-1:0] core_resp_valid_o,
  input  logic       [NumCores-1:0] core_resp_ready_i
);

  tcdm_req_t  [NumCores-1:0] req_head;
  logic       [NumCores-1:0] req_head_valid;
  logic       [NumCores-1:0] req_gnt;
  logic       [NumCores-1:0] resp_space;
  tcdm_resp_t [NumCores-1:0] xbar_resp;
  logic       [NumCores-1:0] xbar_resp_valid;
  bank_req_t  [NumBanks-1:0] bank_req;
  logic       [NumBanks-1:0] bank_req_valid;
  bank_resp_t [NumBanks-1:0] bank_resp;
  logic       [NumBanks-1:0] bank_resp_valid;

  for (genvar c = 0; c < NumCores; c++) begin : gen_req_fifo
    // Core transfer only counts while ready is shown
    stream_fifo #(
      .payload_t (tcdm_req_t),
      .Depth     (FifoDepth)
    ) i_req_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (core_req_i[c]),
      .valid_i (core_req_valid_i[c] & core_req_ready_o[c]),
      .ready_o (core_req_ready_o[c]),
      .data_o  (req_head[c]),
      .valid_o (req_head_valid[c]),
      .ready_i (req_gnt[c])
    );
  end

  tcdm_xbar i_xbar (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .core_req_i        (req_head),
    .core_req_valid_i  (req_head_valid),
    .core_req_gnt_o    (req_gnt),
    .resp_space_i      (resp_space),
    .bank_req_o        (bank_req),
    .bank_req_valid_o  (bank_req_valid),
    .bank_resp_i       (bank_resp),
    .bank_resp_valid_i (bank_resp_valid),
    .core_resp_o       (xbar_resp),
    .core_resp_valid_o (xbar_resp_valid)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_i        (bank_req[b]),
      .req_valid_i  (bank_req_valid[b]),
      .resp_o       (bank_resp[b]),
      .resp_valid_o (bank_resp_valid[b])
    );
  end

  for (genvar c = 0; c < NumCores; c++) begin : gen_resp_fifo
    stream_fifo #(
      .payload_t (tcdm_resp_t),
      .Depth     (FifoDepth)
    ) i_resp_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (xbar_resp[c]),
      .valid_i (xbar_resp_valid[c]),
      .ready_o (resp_space[c]),
      .data_o  (core_resp_o[c]),
      .valid_o (core_resp_valid_o[c]),
      .ready_i (core_resp_ready_i[c])
    );
  end

endmodule

// File: test/tcdm_checks.svh
// Reference memory model, address helper and compare tasks for the TCDM testbench
`ifndef TCDM_CHECKS_SVH
`define TCDM_CHECKS_SVH

data_t ref_mem   [NumBanks][BankWords];
bit    ref_valid [NumBanks][BankWords];
int    error_count = 0;
int    check_count = 0;

// Byte offset in bits 1..0, bank in bits 4..2, row in bits 10..5
function automatic addr_t word_addr(input int bank, input int row);
  return addr_t'((row << 5) | (bank << 2));
endfunction

function automatic void ref_write(input addr_t addr, input data_t wdata, input be_t be);
  for (int i = 0; i < BeWidth; i++) begin
    if (be[i]) begin
      ref_mem[addr[4:2]][addr[10:5]][8*i +: 8] = wdata[8*i +: 8];
    end
  end
  ref_valid[addr[4:2]][addr[10:5]] = 1'b1;
endfunction

function automatic data_t ref_read(input addr_t addr);
  return ref_mem[addr[4:2]][addr[10:5]];
endfunction

task automatic check_resp(input string name, input tcdm_resp_t got, input tcdm_resp_t exp);
  check_count++;
  if (got !== exp) begin
    $display("** Error at %0t: %s is %h, expected %h", $time, name, got.rdata, exp.rdata);
    error_count++;
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    error_count++;
  end
endtask

`endif

// File: test/tb_tcdm_cluster.sv
// Testbench for the TCDM cluster with directed tests and a random mixed test
module tb_tcdm_cluster import tcdm_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int Skew    = 2;
  localparam int Timeout = 200;

  logic                      clk;
  logic                      rst_n;
  tcdm_req_t  [NumCores-1:0] req;
  logic       [NumCores-1:0] req_valid;
  logic       [NumCores-1:0] req_ready;
  tcdm_resp_t [NumCores-1:0] resp;
  logic       [NumCores-1:0] resp_valid;
  logic       [NumCores-1:0] resp_ready;
  logic       [NumCores-1:0] hold;
  logic       [NumCores-1:0] stall;
  tcdm_req_t                 req_q [NumCores][$];
  tcdm_resp_t                exp_q [NumCores][$];
  int                        seed = 22722;

  `include "tcdm_checks.svh"

  tcdm_cluster dut (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .core_req_i        (req),
    .core_req_valid_i  (req_valid),
    .core_req_ready_o  (req_ready),
    .core_resp_o       (resp),
    .core_resp_valid_o (resp_valid),
    .core_resp_ready_i (resp_ready)
  );

  always #10 clk = ~clk;

  task automatic timed_out(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("tests failed");
    $finish;
  endtask

  task automatic add_write(input int c, input addr_t addr, input data_t wdata, input be_t be);
    req_q[c].push_back('{addr: addr, we: 1'b1, wdata: wdata, be: be});
    ref_write(addr, wdata, be);
  endtask

  task automatic add_read(input int c, input addr_t addr);
    req_q[c].push_back('{addr: addr, we: 1'b0, wdata: '0, be: '0});
    exp_q[c].push_back(tcdm_resp_t'(ref_read(addr)));
  endtask

  // One request per handshake, sampled at the falling edge
  task automatic drive_core(input int c);
    int cycles;
    @(posedge clk);
    #Skew;
    while (req_q[c].size() > 0) begin
      req[c]       = req_q[c].pop_front();
      req_valid[c] = 1'b1;
      cycles       = 0;
      @(negedge clk);
      while (!req_ready[c]) begin
        cycles++;
        if (cycles > Timeout) timed_out($sformatf("core %0d request not accepted", c));
        @(negedge clk);
      end
      @(posedge clk);
      #Skew;
    end
    req_valid[c] = 1'b0;
  endtask

  // Responses compared in issue order, with optional random stalls
  task automatic collect_core(input int c);
    int cycles;
    cycles = 0;
    while (exp_q[c].size() > 0) begin
      @(posedge clk);
      #Skew;
      resp_ready[c] = !hold[c] && (!stall[c] || ($random(seed) % 4 != 0));
      @(negedge clk);
      if (resp_valid[c] && resp_ready[c]) begin
        check_resp($sformatf("core_resp_o[%0d]", c), resp[c], exp_q[c].pop_front());
        cycles = 0;
      end else if (!hold[c]) begin
        cycles++;
        if (cycles > Timeout) timed_out($sformatf("core %0d response missing", c));
      end
    end
    @(posedge clk);
    #Skew;
    resp_ready[c] = 1'b1;
  endtask

  // Held core 0 is let go once it backs up and the other cores are done
  task automatic release_held();
    int   cycles;
    logic backed_up;
    cycles    = 0;
    backed_up = 1'b0;
    while (hold != '0) begin
      @(negedge clk);
      backed_up = backed_up | !req_ready[0];
      cycles++;
      if (cycles > Timeout) timed_out("held core did not back up");
      if (backed_up && (exp_q[1].size() + exp_q[2].size() + exp_q[3].size() == 0)) begin
        check_flag("core_resp_valid_o[0]", resp_valid[0], 1'b1);
        hold = '0;
      end
    end
  endtask

  task automatic run_traffic();
    fork
      drive_core(0);
      drive_core(1);
      drive_core(2);
      drive_core(3);
      collect_core(0);
      collect_core(1);
      collect_core(2);
      collect_core(3);
      release_held();
    join
  endtask

  task automatic check_quiet();
    repeat (8) begin
      @(negedge clk);
      for (int c = 0; c < NumCores; c++) begin
        check_flag($sformatf("core_resp_valid_o[%0d]", c), resp_valid[c], 1'b0);
      end
    end
  endtask

  task automatic test_reset();
    for (int c = 0; c < NumCores; c++) begin
      check_flag($sformatf("core_resp_valid_o[%0d]", c), resp_valid[c], 1'b0);
      check_flag($sformatf("core_req_ready_o[%0d]", c), req_ready[c], 1'b1);
    end
  endtask

  // Full and partial byte enables, writes give no response
  task automatic test_single_core();
    add_write(1, word_addr(0, 3), 32'hAABBCCDD, 4'hF);
    add_write(1, word_addr(1, 3), 32'h01234567, 4'hF);
    add_write(1, word_addr(0, 3), 32'h11223344, 4'b0101);
    add_write(1, word_addr(1, 3), 32'h89ABCDEF, 4'b1000);
    add_write(1, word_addr(6, 40), 32'hCAFEF00D, 4'hF);
    add_read(1, word_addr(0, 3));
    add_read(1, word_addr(1, 3));
    add_read(1, word_addr(6, 40));
    run_traffic();
    check_quiet();
  endtask

  task automatic test_parallel();
    for (int c = 0; c < NumCores; c++) begin
      for (int r = 0; r < 4; r++) add_write(c, word_addr(2*c + r%2, 8 + r), $random(seed), 4'hF);
      for (int r = 0; r < 4; r++) add_read(c, word_addr(2*c + r%2, 8 + r));
    end
    run_traffic();
    check_quiet();
  endtask

  // Every core hits bank 5, upper address bits alias
  task automatic test_same_bank();
    for (int r = 0; r < 4; r++) add_write(0, word_addr(5, 20 + r), $random(seed), 4'hF);
    run_traffic();
    for (int round = 0; round < 3; round++) begin
      for (int c = 0; c < NumCores; c++) begin
        for (int r = 0; r < 4; r++) begin
          add_read(c, word_addr(5, 20 + r) | addr_t'((c + round) << 11));
        end
      end
    end
    run_traffic();
    check_quiet();
  endtask

  task automatic test_backpressure();
    hold[0] = 1'b1;
    for (int c = 1; c < NumCores; c++) begin
      for (int r = 0; r < 4; r++) add_read(c, word_addr(2*c + r%2, 8 + r));
    end
    for (int r = 0; r < 12; r++) add_read(0, word_addr(r%2, 8 + r%4));
    run_traffic();
    check_quiet();
  endtask

  // Each core owns sixteen rows, so cross-core order never matters
  task automatic test_random();
    addr_t addr;
    int    bank;
    int    row;
    stall = '1;
    for (int c = 0; c < NumCores; c++) begin
      for (int i = 0; i < 24; i++) begin
        bank = {$random(seed)} % NumBanks;
        row  = c*16 + {$random(seed)} % 16;
        addr = word_addr(bank, row) | ({$random(seed)} & 32'hFFFFF800);
        if (ref_valid[bank][row] && ($random(seed) % 2 != 0)) begin
          add_read(c, addr);
        end else begin
          add_write(c, addr, $random(seed),
                    ref_valid[bank][row] ? be_t'({$random(seed)} % 15 + 1) : 4'hF);
        end
      end
    end
    run_traffic();
    stall = '0;
    check_quiet();
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    req        = '0;
    req_valid  = '0;
    resp_ready = '1;
    hold       = '0;
    stall      = '0;
    repeat (3) @(posedge clk);
    #Skew;
    rst_n = 1'b1;
    @(negedge clk);
    test_reset();
    test_single_core();
    test_parallel();
    test_same_bank();
    test_backpressure();
    test_random();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+test
source/tcdm_pkg.sv
source/stream_fifo.sv
source/tcdm_xbar.sv
source/tcdm_bank.sv
source/tcdm_cluster.sv
test/tb_tcdm_cluster.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_tcdm_cluster -f files.f -o tb_tcdm_cluster

out=$(./obj_dir/tb_tcdm_cluster)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
